// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ctrl_channel
FILELIST = build.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
verilog/spi_frame_pkg.sv
verilog/ctrl_reg_pkg.sv
verilog/ctrl_access_if.sv
verilog/spi_frame_decode.sv
verilog/ctrl_reg_exec.sv
verilog/spi_readback.sv
verilog/ctrl_channel.sv
test/tb_ctrl_channel.sv

// ==== test/tb_ctrl_channel.sv ====
// testbench for the camera control channel: SPI master and directed register tests
`default_nettype none

module tb_ctrl_channel import spi_frame_pkg::*, ctrl_reg_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic                  i_clk_osc_bufg;
	logic                  i_rst_n;
	logic                  i_spi_clk;
	logic                  i_spi_cs_n;
	logic                  i_spi_mosi;
	logic                  o_spi_miso;
	logic                  o_spi_miso_en;
	logic                  o_stream_enable;
	logic                  o_acquisition_start;
	logic                  o_reset_sensor;
	logic                  o_trigger_mode;
	logic                  o_trigger_active;
	logic [TRIG_SRC_W-1:0] ov_trigger_source;
	logic                  o_trigger_soft;
	logic [REG_WD-1:0]     ov_trigger_filter;
	logic [REG_WD-1:0]     ov_trigger_delay;
	logic                  o_line2_mode;
	logic                  o_line3_mode;
	logic [LINE_CNT-1:0]   ov_line_invert;
	logic [LINE_SRC_W-1:0] ov_line_source1;
	logic [REG_WD-1:0]     ov_wb_gain_r;
	logic [REG_WD-1:0]     ov_wb_gain_g;
	logic [REG_WD-1:0]     ov_wb_gain_b;
	logic [INT_W-1:0]      ov_interrupt_en;
	logic [INT_W-1:0]      ov_interrupt_clear;
	logic                  i_sensor_reset_done;
	logic [LINE_CNT-1:0]   iv_line_status;
	logic [INT_W-1:0]      iv_interrupt_state;

	int          errors;
	int          checks;
	int          pulse_cnt [3];
	logic [2:0]  pulse_now;
	logic [2:0]  pulse_prev;
	logic [1:0]  clear_seen;
	logic [2:0]  cs_hist;
	logic [31:0] lfsr;
	logic [15:0] shadow [16];

	ctrl_channel UUT (.*);

	always #5 i_clk_osc_bufg = ~i_clk_osc_bufg;

	// ------------------------------------------------------------------
	// monitors: pulse counts and MISO enable outside a frame
	// ------------------------------------------------------------------
	always @(negedge i_clk_osc_bufg) begin
		if (i_rst_n) begin
			en_idle: assert (!(&cs_hist && i_spi_cs_n && o_spi_miso_en)) else begin
				$display("MISO enable is high while chip select is high");
				errors++;
			end
			pulse_now = {|ov_interrupt_clear, o_reset_sensor, o_trigger_soft};
			for (int k = 0; k < 3; k++) begin
				if (pulse_now[k] && !pulse_prev[k]) begin
					pulse_cnt[k]++;
				end
			end
			if (|ov_interrupt_clear) begin
				clear_seen = ov_interrupt_clear;
			end
			pulse_len: assert ((pulse_now & pulse_prev) == 3'b000) else begin
				$display("a pulse output stayed high for more than one cycle");
				errors++;
			end
			pulse_prev = pulse_now;
		end
		cs_hist = {cs_hist[1:0], i_spi_cs_n};
	end

	task automatic tick(input int n);
		repeat (n) @(posedge i_clk_osc_bufg);
		#1;
	endtask

	// fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		logic        fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[14:0], fb};
		end
		return r;
	endfunction

	task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		value_ok: assert (act === exp) else begin
			$display("FAILED %s: expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	// bits the host can change in each register
	function automatic logic [15:0] wr_mask(input logic [7:0] addr);
		case (addr)
			ADDR_STREAM_CTRL, ADDR_INT_EN: return 16'h0003;
			ADDR_TRIGGER_CTRL, ADDR_TRIGGER_FILTER, ADDR_TRIGGER_DELAY, ADDR_LINE_CTRL,
			ADDR_WB_GAIN_R, ADDR_WB_GAIN_G, ADDR_WB_GAIN_B: return 16'hFFFF;
			default: return 16'h0000;
		endcase
	endfunction

	function automatic logic [15:0] port_value(input logic [7:0] addr);
		case (addr)
			ADDR_TRIGGER_FILTER: return ov_trigger_filter;
			ADDR_TRIGGER_DELAY:  return ov_trigger_delay;
			ADDR_WB_GAIN_R:      return ov_wb_gain_r;
			ADDR_WB_GAIN_G:      return ov_wb_gain_g;
			ADDR_WB_GAIN_B:      return ov_wb_gain_b;
			default:             return 16'h0000;
		endcase
	endfunction

	// ------------------------------------------------------------------
	// SPI master, mode 0, SCLK period of 8 system clocks
	// ------------------------------------------------------------------
	task automatic spi_frame(input logic [31:0] frame, input int n, input bit rd,
		output logic [15:0] miso_word);
		miso_word  = '0;
		i_spi_cs_n = 1'b0;
		tick(4);
		for (int b = 0; b < n; b++) begin
			i_spi_mosi = frame[31-b];
			tick(4);
			if (rd && b >= SPI_HDR_BITS) begin
				miso_en: assert (o_spi_miso_en) else begin
					$display("MISO enable is low in the read data phase, bit %0d", b);
					errors++;
				end
				miso_word = {miso_word[14:0], o_spi_miso};
			end
			i_spi_clk = 1'b1;
			tick(4);
			i_spi_clk = 1'b0;
		end
		tick(4);
		i_spi_cs_n = 1'b1;
		tick(6);
	endtask

	task automatic spi_write(input logic [7:0] addr, input logic [15:0] data);
		logic [15:0] unused;
		spi_frame({CMD_WRITE, addr, data}, 32, 1'b0, unused);
		if (wr_mask(addr) != 16'h0000) begin
			shadow[addr[3:0]] = data & wr_mask(addr);
		end
	endtask

	task automatic spi_read(input logic [7:0] addr, output logic [15:0] data);
		spi_frame({CMD_READ, addr, 16'h0000}, 32, 1'b1, data);
	endtask

	task automatic read_check(input string name, input logic [7:0] addr, input logic [15:0] exp);
		logic [15:0] data;
		spi_read(addr, data);
		check_eq($sformatf("%s @%02h", name, addr), exp, data);
	endtask

	task automatic wait_pulse(input int k, input string name);
		int t;
		t = 0;
		while (pulse_cnt[k] == 0 && t < 100) begin
			tick(1);
			t++;
		end
		if (pulse_cnt[k] == 0) begin
			$display("timed out waiting for the %s pulse", name);
			errors++;
		end
		tick(4);
		check_eq({name, " pulse count"}, 16'h0001, 16'(pulse_cnt[k]));
	endtask

	// ------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------
	task automatic test_reset_values();
		logic [15:0] exp;
		check_eq("reset pulses", 16'h0000, 16'({o_trigger_soft, o_reset_sensor,
			ov_interrupt_clear, o_spi_miso_en}));
		for (int a = 0; a < 16; a++) begin
			exp = (a >= 7 && a <= 9) ? 16'h0100 : (a == 15) ? 16'hCA01 : 16'h0000;
			shadow[a] = exp;
			read_check("reset value", 8'(a), exp);
		end
		read_check("unmapped", 8'h5A, 16'h0000);
	endtask

	task automatic test_random_rw();
		logic [7:0]  addrs [5];
		logic [15:0] d;
		addrs = '{ADDR_TRIGGER_DELAY, ADDR_TRIGGER_FILTER, ADDR_WB_GAIN_R,
			ADDR_WB_GAIN_G, ADDR_WB_GAIN_B};
		for (int i = 0; i < 15; i++) begin
			d = rand_bits(16);
			spi_write(addrs[i % 5], d);
			check_eq("output port", d, port_value(addrs[i % 5]));
			read_check("readback", addrs[i % 5], d);
		end
		// two-bit registers, upper bits are dropped
		d = rand_bits(16);
		spi_write(ADDR_STREAM_CTRL, d);
		check_eq("stream outputs", d & 16'h0003,
			16'({o_acquisition_start, o_stream_enable}));
		read_check("stream readback", ADDR_STREAM_CTRL, d & 16'h0003);
		d = rand_bits(16);
		spi_write(ADDR_INT_EN, d);
		check_eq("interrupt enable", d & 16'h0003, 16'(ov_interrupt_en));
		read_check("interrupt enable readback", ADDR_INT_EN, d & 16'h0003);
	endtask

	task automatic test_field_split();
		logic [15:0] w;
		w = rand_bits(16);
		spi_write(ADDR_TRIGGER_CTRL, w);
		check_eq("trigger fields", 16'({w[5:2], w[1], w[0]}),
			16'({ov_trigger_source, o_trigger_active, o_trigger_mode}));
		read_check("trigger word", ADDR_TRIGGER_CTRL, w);
		w = rand_bits(16);
		spi_write(ADDR_LINE_CTRL, w);
		check_eq("line fields", 16'({w[8:6], w[5:2], w[1], w[0]}),
			16'({ov_line_source1, ov_line_invert, o_line3_mode, o_line2_mode}));
		read_check("line word", ADDR_LINE_CTRL, w);
	endtask

	task automatic test_pulses();
		logic [15:0] d;
		pulse_cnt = '{0, 0, 0};
		spi_write(ADDR_TRIGGER_SOFT, rand_bits(16));
		wait_pulse(0, "soft trigger");
		read_check("soft trigger", ADDR_TRIGGER_SOFT, 16'h0000);
		spi_write(ADDR_SENSOR_RESET, 16'h0001);
		wait_pulse(1, "sensor reset");
		d = rand_bits(2) | 16'h0001;
		spi_write(ADDR_INT_STATE, d);
		wait_pulse(2, "interrupt clear");
		check_eq("interrupt clear bits", d, 16'(clear_seen));
	endtask

	task automatic test_status();
		logic [15:0] s;
		for (int i = 0; i < 3; i++) begin
			s = rand_bits(7);
			iv_interrupt_state  = s[1:0];
			iv_line_status      = s[5:2];
			i_sensor_reset_done = s[6];
			read_check("interrupt state", ADDR_INT_STATE, 16'(s[1:0]));
			read_check("line status", ADDR_LINE_STATUS, 16'(s[5:2]));
			read_check("sensor reset done", ADDR_SENSOR_RESET, 16'(s[6]));
		end
		// read cut off in its data phase, the enable has to drop with CS
		spi_frame({CMD_READ, ADDR_DEVICE_ID, 16'h0000}, 24, 1'b1, s);
		check_eq("aborted read bits", 16'h00CA, s);
		read_check("read after abort", ADDR_DEVICE_ID, 16'hCA01);
	endtask

	task automatic test_dropped_frames();
		logic [15:0] unused;
		// write cut off after 20 bits, then a frame with an unknown command
		spi_frame({CMD_WRITE, ADDR_TRIGGER_DELAY, ~shadow[5]}, 20, 1'b0, unused);
		spi_frame({8'h42, ADDR_WB_GAIN_R, ~shadow[7]}, 32, 1'b0, unused);
		spi_frame({8'h42, ADDR_STREAM_CTRL, ~shadow[0]}, 32, 1'b0, unused);
		check_eq("delay output held", shadow[5], ov_trigger_delay);
		for (int a = 0; a < 11; a++) begin
			if (wr_mask(8'(a)) != 16'h0000) begin
				read_check("register held", 8'(a), shadow[a]);
			end
		end
	endtask

	initial begin
		i_clk_osc_bufg      = 1'b0;
		i_rst_n             = 1'b0;
		i_spi_clk           = 1'b0;
		i_spi_cs_n          = 1'b1;
		i_spi_mosi          = 1'b0;
		i_sensor_reset_done = 1'b0;
		iv_line_status      = '0;
		iv_interrupt_state  = '0;
		lfsr                = 32'h3333;
		errors              = 0;
		checks              = 0;
		pulse_prev          = '0;
		cs_hist             = '0;
		clear_seen          = '0;
		pulse_cnt           = '{0, 0, 0};
		tick(3);
		i_rst_n = 1'b1;
		tick(2);
		test_reset_values();
		test_random_rw();
		test_field_split();
		test_pulses();
		test_status();
		test_dropped_frames();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// whole-run limit
	initial begin
		repeat (100000) @(posedge i_clk_osc_bufg);
		$display("simulation did not finish in time");
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/ctrl_access_if.sv ====
// register access interface: requests from the SPI decoder, responses from the register file
`default_nettype none

interface ctrl_access_if import spi_frame_pkg::*, ctrl_reg_pkg::*; ();

	// request, valid for one cycle, always accepted
	logic                  req_valid;
	logic                  req_write;
	logic [SPI_ADDR_W-1:0] req_addr;
	logic [SPI_DATA_W-1:0] req_wdata;

	// read response, one cycle after the read request
	logic                  rsp_valid;
	logic [REG_WD-1:0]     rsp_rdata;

	modport decode_mp (
		output req_valid, req_write, req_addr, req_wdata
	);

	modport exec_mp (
		input  req_valid, req_write, req_addr, req_wdata,
		output rsp_valid, rsp_rdata
	);

	modport readback_mp (
		input  rsp_valid, rsp_rdata
	);

endinterface

`default_nettype wire

// ==== verilog/ctrl_channel.sv ====
// control channel top: SPI decode, register file and MISO readback of the camera registers
`default_nettype none

module ctrl_channel import ctrl_reg_pkg::*; (
	input  wire                   i_clk_osc_bufg,
	input  wire                   i_rst_n,
	// SPI pins
	input  wire                   i_spi_clk,
	input  wire                   i_spi_cs_n,
	input  wire                   i_spi_mosi,
	output logic                  o_spi_miso,
	output logic                  o_spi_miso_en,
	// control outputs
	output logic                  o_stream_enable,
	output logic                  o_acquisition_start,
	output logic                  o_reset_sensor,
	output logic                  o_trigger_mode,
	output logic                  o_trigger_active,
	output logic [TRIG_SRC_W-1:0] ov_trigger_source,
	output logic                  o_trigger_soft,
	output logic [REG_WD-1:0]     ov_trigger_filter,
	output logic [REG_WD-1:0]     ov_trigger_delay,
	output logic                  o_line2_mode,
	output logic                  o_line3_mode,
	output logic [LINE_CNT-1:0]   ov_line_invert,
	output logic [LINE_SRC_W-1:0] ov_line_source1,
	output logic [REG_WD-1:0]     ov_wb_gain_r,
	output logic [REG_WD-1:0]     ov_wb_gain_g,
	output logic [REG_WD-1:0]     ov_wb_gain_b,
	output logic [INT_W-1:0]      ov_interrupt_en,
	output logic [INT_W-1:0]      ov_interrupt_clear,
	// status inputs
	input  wire                   i_sensor_reset_done,
	input  wire  [LINE_CNT-1:0]   iv_line_status,
	input  wire  [INT_W-1:0]      iv_interrupt_state
);

	logic miso_shift;
	logic frame_active;

	ctrl_access_if access ();

	spi_frame_decode spi_frame_decode_inst (
		.i_clk_osc_bufg,
		.i_rst_n,
		.i_spi_clk,
		.i_spi_cs_n,
		.i_spi_mosi,
		.access         (access.decode_mp),
		.o_miso_shift   (miso_shift),
		.o_frame_active (frame_active)
	);

	// register file, port names match the top level
	ctrl_reg_exec ctrl_reg_exec_inst (.*);

	spi_readback spi_readback_inst (
		.i_clk_osc_bufg,
		.i_rst_n,
		.access         (access.readback_mp),
		.i_miso_shift   (miso_shift),
		.i_frame_active (frame_active),
		.o_spi_miso,
		.o_spi_miso_en
	);

endmodule

`default_nettype wire

// ==== verilog/ctrl_reg_exec.sv ====
// control register file: holds the camera control registers and answers read requests
`default_nettype none

module ctrl_reg_exec import ctrl_reg_pkg::*; (
	input  wire                   i_clk_osc_bufg,
	input  wire                   i_rst_n,
	ctrl_access_if.exec_mp        access,
	output logic                  o_stream_enable,
	output logic                  o_acquisition_start,
	output logic                  o_reset_sensor,
	output logic                  o_trigger_mode,
	output logic                  o_trigger_active,
	output logic [TRIG_SRC_W-1:0] ov_trigger_source,
	output logic                  o_trigger_soft,
	output logic [REG_WD-1:0]     ov_trigger_filter,
	output logic [REG_WD-1:0]     ov_trigger_delay,
	output logic                  o_line2_mode,
	output logic                  o_line3_mode,
	output logic [LINE_CNT-1:0]   ov_line_invert,
	output logic [LINE_SRC_W-1:0] ov_line_source1,
	output logic [REG_WD-1:0]     ov_wb_gain_r,
	output logic [REG_WD-1:0]     ov_wb_gain_g,
	output logic [REG_WD-1:0]     ov_wb_gain_b,
	output logic [INT_W-1:0]      ov_interrupt_en,
	output logic [INT_W-1:0]      ov_interrupt_clear,
	input  wire                   i_sensor_reset_done,
	input  wire  [LINE_CNT-1:0]   iv_line_status,
	input  wire  [INT_W-1:0]      iv_interrupt_state
);

	ctrl_word_u        trig_q;
	ctrl_word_u        line_q;
	logic              wr_en;
	logic              rd_en;
	logic [REG_WD-1:0] rd_word;

	assign wr_en = access.req_valid && access.req_write;
	assign rd_en = access.req_valid && !access.req_write;

	// ---------------------------------------------------------------------
	// writable registers
	// ---------------------------------------------------------------------
	always_ff @(posedge i_clk_osc_bufg) begin
		if (!i_rst_n) begin
			o_stream_enable     <= 1'b0;
			o_acquisition_start <= 1'b0;
			trig_q              <= '0;
			line_q              <= '0;
			ov_trigger_filter   <= '0;
			ov_trigger_delay    <= '0;
			ov_wb_gain_r        <= WB_GAIN_RESET;
			ov_wb_gain_g        <= WB_GAIN_RESET;
			ov_wb_gain_b        <= WB_GAIN_RESET;
			ov_interrupt_en     <= '0;
		end else if (wr_en) begin
			case (access.req_addr)
				ADDR_STREAM_CTRL: begin
					o_stream_enable     <= access.req_wdata[0];
					o_acquisition_start <= access.req_wdata[1];
				end
				ADDR_TRIGGER_CTRL:   trig_q            <= access.req_wdata;
				ADDR_TRIGGER_FILTER: ov_trigger_filter <= access.req_wdata;
				ADDR_TRIGGER_DELAY:  ov_trigger_delay  <= access.req_wdata;
				ADDR_LINE_CTRL:      line_q            <= access.req_wdata;
				ADDR_WB_GAIN_R:      ov_wb_gain_r      <= access.req_wdata;
				ADDR_WB_GAIN_G:      ov_wb_gain_g      <= access.req_wdata;
				ADDR_WB_GAIN_B:      ov_wb_gain_b      <= access.req_wdata;
				ADDR_INT_EN:         ov_interrupt_en   <= access.req_wdata[INT_W-1:0];
				default: ;
			endcase
		end
	end

	// field split of the trigger and line words
	assign o_trigger_mode    = trig_q.trig.mode;
	assign o_trigger_active  = trig_q.trig.active;
	assign ov_trigger_source = trig_q.trig.source;
	assign o_line2_mode      = line_q.line.line2_mode;
	assign o_line3_mode      = line_q.line.line3_mode;
	assign ov_line_invert    = line_q.line.invert;
	assign ov_line_source1   = line_q.line.source1;

	// ---------------------------------------------------------------------
	// one-cycle pulses, requests never last longer
	// ---------------------------------------------------------------------
	always_ff @(posedge i_clk_osc_bufg) begin
		if (!i_rst_n) begin
			o_trigger_soft     <= 1'b0;
			o_reset_sensor     <= 1'b0;
			ov_interrupt_clear <= '0;
		end else begin
			o_trigger_soft     <= wr_en && access.req_addr == ADDR_TRIGGER_SOFT;
			o_reset_sensor     <= wr_en && access.req_addr == ADDR_SENSOR_RESET
				&& access.req_wdata[0];
			ov_interrupt_clear <= (wr_en && access.req_addr == ADDR_INT_STATE) ?
				access.req_wdata[INT_W-1:0] : '0;
		end
	end

	// ---------------------------------------------------------------------
	// read mux and response
	// ---------------------------------------------------------------------
	always_comb begin
		case (access.req_addr)
			ADDR_STREAM_CTRL:    rd_word = REG_WD'({o_acquisition_start, o_stream_enable});
			ADDR_SENSOR_RESET:   rd_word = REG_WD'(i_sensor_reset_done);
			ADDR_TRIGGER_CTRL:   rd_word = trig_q;
			ADDR_TRIGGER_FILTER: rd_word = ov_trigger_filter;
			ADDR_TRIGGER_DELAY:  rd_word = ov_trigger_delay;
			ADDR_LINE_CTRL:      rd_word = line_q;
			ADDR_WB_GAIN_R:      rd_word = ov_wb_gain_r;
			ADDR_WB_GAIN_G:      rd_word = ov_wb_gain_g;
			ADDR_WB_GAIN_B:      rd_word = ov_wb_gain_b;
			ADDR_INT_EN:         rd_word = REG_WD'(ov_interrupt_en);
			ADDR_INT_STATE:      rd_word = REG_WD'(iv_interrupt_state);
			ADDR_LINE_STATUS:    rd_word = REG_WD'(iv_line_status);
			ADDR_DEVICE_ID:      rd_word = DEVICE_ID;
			// soft trigger and unmapped addresses
			default:             rd_word = '0;
		endcase
	end

	always_ff @(posedge i_clk_osc_bufg) begin
		if (!i_rst_n) begin
			access.rsp_valid <= 1'b0;
		end else begin
			access.rsp_valid <= rd_en;
		end
	end

	always_ff @(posedge i_clk_osc_bufg) begin
		if (rd_en) begin
			access.rsp_rdata <= rd_word;
		end
	end

	// a response one cycle after its read, with no new request beside it
	a_rsp_follows_read: assert property (@(posedge i_clk_osc_bufg) disable iff (!i_rst_n)
		rd_en |=> access.rsp_valid && !access.req_valid);

	// single-cycle requests from the decoder give single-cycle pulses
	a_pulse_one_cycle: assert property (@(posedge i_clk_osc_bufg) disable iff (!i_rst_n)
		(o_trigger_soft || o_reset_sensor || |ov_interrupt_clear)
		|=> !(o_trigger_soft || o_reset_sensor || |ov_interrupt_clear));

endmodule

`default_nettype wire

// ==== verilog/ctrl_reg_pkg.sv ====
// control register package: register map, field widths, reset values and word layouts
`default_nettype none

package ctrl_reg_pkg;

	// field widths
	localparam int REG_WD     = 16;
	localparam int TRIG_SRC_W = 4;
	localparam int LINE_CNT   = 4;
	localparam int LINE_SRC_W = 3;
	localparam int INT_W      = 2;
	// readback bit index
	localparam int RD_CNT_W   = $clog2(REG_WD);

	// ---------------------------------------------------------------------
	// register map
	// ---------------------------------------------------------------------
	localparam logic [7:0] ADDR_STREAM_CTRL    = 8'h00;
	localparam logic [7:0] ADDR_SENSOR_RESET   = 8'h01;
	localparam logic [7:0] ADDR_TRIGGER_CTRL   = 8'h02;
	localparam logic [7:0] ADDR_TRIGGER_SOFT   = 8'h03;
	localparam logic [7:0] ADDR_TRIGGER_FILTER = 8'h04;
	localparam logic [7:0] ADDR_TRIGGER_DELAY  = 8'h05;
	localparam logic [7:0] ADDR_LINE_CTRL      = 8'h06;
	localparam logic [7:0] ADDR_WB_GAIN_R      = 8'h07;
	localparam logic [7:0] ADDR_WB_GAIN_G      = 8'h08;
	localparam logic [7:0] ADDR_WB_GAIN_B      = 8'h09;
	localparam logic [7:0] ADDR_INT_EN         = 8'h0A;
	localparam logic [7:0] ADDR_INT_STATE      = 8'h0B;
	localparam logic [7:0] ADDR_LINE_STATUS    = 8'h0C;
	localparam logic [7:0] ADDR_DEVICE_ID      = 8'h0F;

	// unity gain after reset
	localparam logic [REG_WD-1:0] WB_GAIN_RESET = 16'h0100;
	localparam logic [REG_WD-1:0] DEVICE_ID     = 16'hCA01;

	// ---------------------------------------------------------------------
	// trigger and line control words, bit 0 first from the bottom
	// ---------------------------------------------------------------------
	typedef struct packed {
		logic [REG_WD-TRIG_SRC_W-3:0] rsvd;
		logic [TRIG_SRC_W-1:0]        source;
		logic                         active;
		logic                         mode;
	} trig_word_t;

	typedef struct packed {
		logic [REG_WD-LINE_SRC_W-LINE_CNT-3:0] rsvd;
		logic [LINE_SRC_W-1:0]                 source1;
		logic [LINE_CNT-1:0]                   invert;
		logic                                  line3_mode;
		logic                                  line2_mode;
	} line_word_t;

	typedef union packed {
		trig_word_t trig;
		line_word_t line;
	} ctrl_word_u;

endpackage

`default_nettype wire

// ==== verilog/spi_frame_decode.sv ====
// SPI frame decoder: samples the SPI pins and turns frames into register requests
`default_nettype none

module spi_frame_decode import spi_frame_pkg::*; (
	input  wire             i_clk_osc_bufg,
	input  wire             i_rst_n,
	input  wire             i_spi_clk,
	input  wire             i_spi_cs_n,
	input  wire             i_spi_mosi,
	ctrl_access_if.decode_mp access,
	output logic            o_miso_shift,
	output logic            o_frame_active
);

	logic [2:0]                sclk_sync;
	logic [1:0]                cs_n_sync;
	logic [1:0]                mosi_sync;
	logic                      cs_n_s;
	logic                      sclk_rise;
	logic                      sclk_fall;
	logic                      shift_en;
	logic                      hdr_done;
	logic                      frame_done;
	logic [SPI_CNT_W-1:0]      bit_cnt;
	logic [SPI_FRAME_BITS-1:0] frame_sr;
	logic [SPI_FRAME_BITS-1:0] frame_next;
	logic [SPI_ADDR_W-1:0]     addr_q;
	logic                      rd_phase;
	logic                      req_valid_q;
	logic                      req_write_q;

	// ---------------------------------------------------------------------
	// pin synchronizers, third sclk stage for edge detection
	// ---------------------------------------------------------------------
	always_ff @(posedge i_clk_osc_bufg) begin
		if (!i_rst_n) begin
			sclk_sync <= '0;
			cs_n_sync <= '1;
			mosi_sync <= '0;
		end else begin
			sclk_sync <= {sclk_sync[1:0], i_spi_clk};
			cs_n_sync <= {cs_n_sync[0], i_spi_cs_n};
			mosi_sync <= {mosi_sync[0], i_spi_mosi};
		end
	end

	assign cs_n_s    = cs_n_sync[1];
	assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];

	// ---------------------------------------------------------------------
	// bit counter and requests
	// ---------------------------------------------------------------------
	assign shift_en   = !cs_n_s && sclk_rise && bit_cnt != SPI_CNT_W'(SPI_FRAME_BITS);
	assign frame_next = {frame_sr[SPI_FRAME_BITS-2:0], mosi_sync[1]};
	assign hdr_done   = bit_cnt == SPI_CNT_W'(SPI_HDR_BITS - 1);
	assign frame_done = bit_cnt == SPI_CNT_W'(SPI_FRAME_BITS - 1);

	always_ff @(posedge i_clk_osc_bufg) begin
		if (!i_rst_n) begin
			bit_cnt     <= '0;
			rd_phase    <= 1'b0;
			req_valid_q <= 1'b0;
			req_write_q <= 1'b0;
		end else begin
			req_valid_q <= 1'b0;
			req_write_q <= 1'b0;
			if (cs_n_s) begin
				// frame over or aborted, nothing pending survives
				bit_cnt  <= '0;
				rd_phase <= 1'b0;
			end else if (shift_en) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (hdr_done && frame_next[SPI_HDR_BITS-1 -: SPI_CMD_W] == CMD_READ) begin
					req_valid_q <= 1'b1;
					rd_phase    <= 1'b1;
				end
				if (frame_done && frame_next[SPI_FRAME_BITS-1 -: SPI_CMD_W] == CMD_WRITE) begin
					req_valid_q <= 1'b1;
					req_write_q <= 1'b1;
				end
			end
		end
	end

	// frame payload
	always_ff @(posedge i_clk_osc_bufg) begin
		if (shift_en) begin
			frame_sr <= frame_next;
			if (hdr_done) begin
				addr_q <= frame_next[SPI_ADDR_W-1:0];
			end
		end
	end

	assign access.req_valid = req_valid_q;
	assign access.req_write = req_write_q;
	assign access.req_addr  = addr_q;
	assign access.req_wdata = frame_sr[SPI_DATA_W-1:0];

	// the MSB is on the pin before the 16th fall, so shifting starts one fall later
	assign o_miso_shift   = sclk_fall && !cs_n_s && rd_phase
		&& bit_cnt != SPI_CNT_W'(SPI_HDR_BITS);
	assign o_frame_active = !cs_n_s;

endmodule

`default_nettype wire

// ==== verilog/spi_frame_pkg.sv ====
// SPI frame package: frame layout, command codes and field widths of the host link
`default_nettype none

package spi_frame_pkg;

	// ---------------------------------------------------------------------
	// frame layout
	// ---------------------------------------------------------------------
	// one frame is command, address, data, sent MSB first
	localparam int SPI_CMD_W      = 8;
	localparam int SPI_ADDR_W     = 8;
	localparam int SPI_DATA_W     = 16;
	localparam int SPI_FRAME_BITS = SPI_CMD_W + SPI_ADDR_W + SPI_DATA_W;

	// command plus address, read requests go out after these bits
	localparam int SPI_HDR_BITS   = SPI_CMD_W + SPI_ADDR_W;

	// bit counter has to hold the full count
	localparam int SPI_CNT_W      = $clog2(SPI_FRAME_BITS + 1);

	// ---------------------------------------------------------------------
	// command codes
	// ---------------------------------------------------------------------
	// anything else on the command field drops the frame
	localparam logic [SPI_CMD_W-1:0] CMD_WRITE = 8'h80;
	localparam logic [SPI_CMD_W-1:0] CMD_READ  = 8'h81;

endpackage

`default_nettype wire

// ==== verilog/spi_readback.sv ====
// SPI readback: loads read data and shifts it out on MISO during the data phase
`default_nettype none

module spi_readback import ctrl_reg_pkg::*; (
	input  wire                i_clk_osc_bufg,
	input  wire                i_rst_n,
	ctrl_access_if.readback_mp access,
	input  wire                i_miso_shift,
	input  wire                i_frame_active,
	output logic               o_spi_miso,
	output logic               o_spi_miso_en
);

	logic [REG_WD-1:0]   shift_q;
	logic [RD_CNT_W-1:0] shift_cnt;
	logic                busy_q;

	// busy from load until the last bit has gone out
	always_ff @(posedge i_clk_osc_bufg) begin
		if (!i_rst_n) begin
			busy_q    <= 1'b0;
			shift_cnt <= '0;
		end else if (!i_frame_active) begin
			busy_q <= 1'b0;
		end else if (access.rsp_valid) begin
			busy_q    <= 1'b1;
			shift_cnt <= '0;
		end else if (i_miso_shift && busy_q) begin
			shift_cnt <= shift_cnt + 1'b1;
			if (&shift_cnt) begin
				busy_q <= 1'b0;
			end
		end
	end

	// data word, MSB first
	always_ff @(posedge i_clk_osc_bufg) begin
		if (access.rsp_valid) begin
			shift_q <= access.rsp_rdata;
		end else if (i_miso_shift) begin
			shift_q <= {shift_q[REG_WD-2:0], 1'b0};
		end
	end

	assign o_spi_miso    = shift_q[REG_WD-1];
	// release the line as soon as CS goes high
	assign o_spi_miso_en = busy_q & i_frame_active;

	// every strobe of the data phase finds a loaded word
	a_shift_loaded: assert property (@(posedge i_clk_osc_bufg) disable iff (!i_rst_n)
		i_miso_shift |-> busy_q);

endmodule

`default_nettype wire
